// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hw/dcache_pkg.sv
  - hw/dcache_array_if.sv
  - hw/dcache_data_ram.sv
  - hw/dcache_tag_ram.sv
  - hw/dcache_wb_fsm.sv
  - hw/dcache_ctrl.sv
  - hw/dcache_top.sv
  - target: simulation
    files:
      - verif/dcache_tb_mem.sv
      - verif/dcache_tb.sv

// ==== hw/dcache_array_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface dcache_array_if;

    // read side indexed straight from the request address
    dcache_pkg::index_t     rd_index;
    dcache_pkg::index_t     wr_index;

    // line storage, per-way byte enables
    dcache_pkg::line_strb_t data_we    [dcache_pkg::NUM_WAYS];
    dcache_pkg::line_t      data_wdata;
    dcache_pkg::line_t      data_rdata [dcache_pkg::NUM_WAYS];

    // tag store, valid is set by every tag write
    logic [dcache_pkg::NUM_WAYS-1:0] tag_we;
    dcache_pkg::tag_t       tag_wdata;
    logic                   dirty_wdata;
    dcache_pkg::tag_t       tag_rdata   [dcache_pkg::NUM_WAYS];
    logic                   valid_rdata [dcache_pkg::NUM_WAYS];
    logic                   dirty_rdata [dcache_pkg::NUM_WAYS];

    modport ctrl (
        output rd_index, wr_index,
        output data_we, data_wdata, tag_we, tag_wdata, dirty_wdata,
        input  data_rdata, tag_rdata, valid_rdata, dirty_rdata
    );

    modport array (
        input  rd_index, wr_index,
        input  data_we, data_wdata, tag_we, tag_wdata, dirty_wdata,
        output data_rdata, tag_rdata, valid_rdata, dirty_rdata
    );

endinterface

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic [dcache_pkg::ADDR_W-1:0]   i_addr,
    input  logic                            i_rvalid,
    input  logic                            i_wvalid,
    input  logic [dcache_pkg::DATA_W-1:0]   i_wdata,
    input  logic [dcache_pkg::DATA_W/8-1:0] i_wstrb,
    output logic                            o_rready,
    output logic                            o_wready,
    output logic [dcache_pkg::DATA_W-1:0]   o_rdata,
    output logic                            o_idle,
    output logic                            o_mem_rvalid,
    input  logic                            i_mem_rready,
    output logic [dcache_pkg::ADDR_W-1:0]   o_mem_raddr,
    input  dcache_pkg::line_t               i_mem_rdata,
    dcache_array_if.ctrl                    arr,
    output logic                            o_wb_start,
    output dcache_pkg::line_t               o_wb_line,
    output logic [dcache_pkg::ADDR_W-1:0]   o_wb_addr,
    output logic                            o_wb_dirty,
    input  logic                            i_wb_finish,
    output logic                            o_wb_clear
);

    dcache_pkg::ctrl_state_e state_q;
    dcache_pkg::ctrl_state_e state_d;

    // request buffer
    logic [dcache_pkg::ADDR_W-1:0]   req_addr_q;
    logic [dcache_pkg::DATA_W-1:0]   req_wdata_q;
    logic [dcache_pkg::DATA_W/8-1:0] req_wstrb_q;
    logic                            req_write_q;

    // lru bit holds the most recently used way of each set
    logic [dcache_pkg::NUM_SETS-1:0] lru_q;
    logic                            vic_way_q;
    dcache_pkg::line_t               refill_q;

    dcache_pkg::index_t            req_index;
    dcache_pkg::tag_t              req_tag;
    logic [dcache_pkg::WORD_OFF_W-1:0] req_word;
    logic                          sample;
    logic [dcache_pkg::NUM_WAYS-1:0] hit;
    logic                          cache_hit;
    logic                          hit_way;
    logic                          vic_way;
    dcache_pkg::line_strb_t        req_mask;
    dcache_pkg::line_t             req_bits;
    dcache_pkg::line_t             req_line;
    dcache_pkg::line_t             merged_line;
    dcache_pkg::line_t             rd_line;

    assign sample    = (state_q == dcache_pkg::IDLE) && (i_rvalid || i_wvalid);
    assign req_index = req_addr_q[dcache_pkg::BYTE_OFF_W +: dcache_pkg::INDEX_W];
    assign req_tag   = req_addr_q[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_word  = req_addr_q[dcache_pkg::BYTE_OFF_W-1 -: dcache_pkg::WORD_OFF_W];

    assign arr.rd_index = i_addr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::INDEX_W];
    assign arr.wr_index = req_index;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q     <= dcache_pkg::IDLE;
            req_write_q <= 1'b0;
            lru_q       <= '0;
        end else begin
            state_q <= state_d;
            if (sample) begin
                req_write_q <= i_wvalid;
            end
            if (state_q == dcache_pkg::LOOKUP && cache_hit) begin
                lru_q[req_index] <= hit_way;
            end else if (state_q == dcache_pkg::REFILL) begin
                lru_q[req_index] <= vic_way_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            req_addr_q  <= i_addr;
            req_wdata_q <= i_wdata;
            req_wstrb_q <= i_wstrb;
        end
        if (state_q == dcache_pkg::LOOKUP && !cache_hit) begin
            vic_way_q <= vic_way;
        end
        if (state_q == dcache_pkg::MISS && i_mem_rready) begin
            refill_q <= i_mem_rdata;
        end
    end

    // tag compare on the registered array outputs
    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit[w] = arr.valid_rdata[w] && (arr.tag_rdata[w] == req_tag);
        end
    end

    assign cache_hit = |hit;
    assign hit_way   = !hit[0];
    assign vic_way   = !lru_q[req_index];

    // store bytes moved to the addressed word, empty for reads
    assign req_mask = req_write_q ?
        (dcache_pkg::line_strb_t'(req_wstrb_q) << (req_word * (dcache_pkg::DATA_W / 8))) : '0;
    assign req_line = dcache_pkg::line_t'(req_wdata_q) << (req_word * dcache_pkg::DATA_W);

    always_comb begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            req_bits[b*8 +: 8] = {8{req_mask[b]}};
        end
    end

    assign merged_line = (refill_q & ~req_bits) | (req_line & req_bits);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::IDLE: begin
                if (sample) begin
                    state_d = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                state_d = cache_hit ? dcache_pkg::IDLE : dcache_pkg::MISS;
            end
            dcache_pkg::MISS: begin
                if (i_mem_rready) begin
                    state_d = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                state_d = dcache_pkg::WAIT_WRITE;
            end
            dcache_pkg::WAIT_WRITE: begin
                if (i_wb_finish) begin
                    state_d = dcache_pkg::IDLE;
                end
            end
            default: begin
                state_d = dcache_pkg::IDLE;
            end
        endcase
    end

    // array writes and processor handshake
    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            arr.data_we[w] = '0;
        end
        arr.tag_we      = '0;
        arr.data_wdata  = req_line;
        arr.tag_wdata   = req_tag;
        arr.dirty_wdata = 1'b0;
        o_rready        = 1'b0;
        o_wready        = 1'b0;
        case (state_q)
            dcache_pkg::LOOKUP: begin
                if (cache_hit) begin
                    o_rready = !req_write_q;
                    o_wready = req_write_q;
                    if (req_write_q) begin
                        arr.data_we[hit_way] = req_mask;
                        arr.tag_we[hit_way]  = 1'b1;
                        arr.dirty_wdata      = 1'b1;
                    end
                end
            end
            dcache_pkg::REFILL: begin
                // whole line, with the pending store bytes already merged
                arr.data_we[vic_way_q] = '1;
                arr.tag_we[vic_way_q]  = 1'b1;
                arr.data_wdata         = merged_line;
                arr.dirty_wdata        = req_write_q;
            end
            dcache_pkg::WAIT_WRITE: begin
                o_rready = i_wb_finish && !req_write_q;
                o_wready = i_wb_finish && req_write_q;
            end
            default: begin
            end
        endcase
    end

    // victim handoff to the write-back engine
    assign o_wb_start = (state_q == dcache_pkg::LOOKUP) && !cache_hit;
    assign o_wb_line  = arr.data_rdata[vic_way];
    assign o_wb_addr  = {arr.tag_rdata[vic_way], req_index, {dcache_pkg::BYTE_OFF_W{1'b0}}};
    assign o_wb_dirty = arr.valid_rdata[vic_way] && arr.dirty_rdata[vic_way];
    assign o_wb_clear = (state_q == dcache_pkg::WAIT_WRITE) && i_wb_finish;

    assign o_mem_rvalid = (state_q == dcache_pkg::MISS);
    assign o_mem_raddr  = {req_addr_q[dcache_pkg::ADDR_W-1:dcache_pkg::BYTE_OFF_W],
                           {dcache_pkg::BYTE_OFF_W{1'b0}}};

    // hit way in LOOKUP, merged refill line after a miss
    assign rd_line = (state_q == dcache_pkg::WAIT_WRITE) ? merged_line : arr.data_rdata[hit_way];
    assign o_rdata = rd_line[req_word * dcache_pkg::DATA_W +: dcache_pkg::DATA_W];
    assign o_idle  = (state_q == dcache_pkg::IDLE);

endmodule

`default_nettype wire

// ==== hw/dcache_data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data_ram #(
    parameter int WAY = 0
) (
    input  logic          clk,
    dcache_array_if.array arr
);

    dcache_pkg::line_t mem [dcache_pkg::NUM_SETS];
    dcache_pkg::line_t rdata_q;

    // byte-enabled write port
    always_ff @(posedge clk) begin
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            if (arr.data_we[WAY][b]) begin
                mem[arr.wr_index][b*8 +: 8] <= arr.data_wdata[b*8 +: 8];
            end
        end
    end

    // registered read, old data on a same-edge write
    always_ff @(posedge clk) begin
        rdata_q <= mem[arr.rd_index];
    end

    assign arr.data_rdata[WAY] = rdata_q;

endmodule

`default_nettype wire

// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // address and word geometry
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;

    // 16 sets of 4-word lines per way
    localparam int INDEX_W    = 4;
    localparam int WORD_OFF_W = 2;
    localparam int BYTE_OFF_W = 4;
    localparam int TAG_W      = ADDR_W - INDEX_W - BYTE_OFF_W;

    localparam int NUM_SETS   = 1 << INDEX_W;
    localparam int LINE_WORDS = 1 << WORD_OFF_W;
    localparam int LINE_BYTES = 1 << BYTE_OFF_W;
    localparam int LINE_W     = LINE_WORDS * DATA_W;
    localparam int NUM_WAYS   = 2;

    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [LINE_BYTES-1:0] line_strb_t;

    // main controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        WAIT_WRITE
    } ctrl_state_e;

    // write-back engine states
    typedef enum logic [1:0] {
        WB_INIT,
        WB_WRITE,
        WB_FINISH
    } wb_state_e;

endpackage

`default_nettype wire

// ==== hw/dcache_tag_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_ram #(
    parameter int WAY = 0
) (
    input  logic          clk,
    input  logic          rstn,
    dcache_array_if.array arr
);

    dcache_pkg::tag_t                tag_mem [dcache_pkg::NUM_SETS];
    logic [dcache_pkg::NUM_SETS-1:0] valid_q;
    logic [dcache_pkg::NUM_SETS-1:0] dirty_q;

    dcache_pkg::tag_t tag_rd_q;
    logic             valid_rd_q;
    logic             dirty_rd_q;

    always_ff @(posedge clk) begin
        if (arr.tag_we[WAY]) begin
            tag_mem[arr.wr_index] <= arr.tag_wdata;
        end
        tag_rd_q <= tag_mem[arr.rd_index];
    end

    // valid and dirty bits start out clear
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            valid_rd_q <= 1'b0;
            dirty_rd_q <= 1'b0;
        end else begin
            if (arr.tag_we[WAY]) begin
                valid_q[arr.wr_index] <= 1'b1;
                dirty_q[arr.wr_index] <= arr.dirty_wdata;
            end
            valid_rd_q <= valid_q[arr.rd_index];
            dirty_rd_q <= dirty_q[arr.rd_index];
        end
    end

    assign arr.tag_rdata[WAY]   = tag_rd_q;
    assign arr.valid_rdata[WAY] = valid_rd_q;
    assign arr.dirty_rdata[WAY] = dirty_rd_q;

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                            clk,
    input  logic                            rstn,
    // processor load/store port
    input  logic [dcache_pkg::ADDR_W-1:0]   i_addr,
    input  logic                            i_rvalid,
    input  logic                            i_wvalid,
    input  logic [dcache_pkg::DATA_W-1:0]   i_wdata,
    input  logic [dcache_pkg::DATA_W/8-1:0] i_wstrb,
    output logic                            o_rready,
    output logic                            o_wready,
    output logic [dcache_pkg::DATA_W-1:0]   o_rdata,
    output logic                            o_idle,
    // main memory, whole lines
    output logic                            o_mem_rvalid,
    input  logic                            i_mem_rready,
    output logic [dcache_pkg::ADDR_W-1:0]   o_mem_raddr,
    input  logic [dcache_pkg::LINE_W-1:0]   i_mem_rdata,
    output logic                            o_mem_wvalid,
    input  logic                            i_mem_bvalid,
    output logic [dcache_pkg::ADDR_W-1:0]   o_mem_waddr,
    output logic [dcache_pkg::LINE_W-1:0]   o_mem_wdata
);

    logic                          wb_start;
    dcache_pkg::line_t             wb_line;
    logic [dcache_pkg::ADDR_W-1:0] wb_addr;
    logic                          wb_dirty;
    logic                          wb_finish;
    logic                          wb_clear;

    dcache_array_if arr_if ();

    dcache_ctrl ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_addr       (i_addr),
        .i_rvalid     (i_rvalid),
        .i_wvalid     (i_wvalid),
        .i_wdata      (i_wdata),
        .i_wstrb      (i_wstrb),
        .o_rready     (o_rready),
        .o_wready     (o_wready),
        .o_rdata      (o_rdata),
        .o_idle       (o_idle),
        .o_mem_rvalid (o_mem_rvalid),
        .i_mem_rready (i_mem_rready),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rdata  (i_mem_rdata),
        .arr          (arr_if.ctrl),
        .o_wb_start   (wb_start),
        .o_wb_line    (wb_line),
        .o_wb_addr    (wb_addr),
        .o_wb_dirty   (wb_dirty),
        .i_wb_finish  (wb_finish),
        .o_wb_clear   (wb_clear)
    );

    dcache_data_ram #(.WAY(0)) data_ram_0 (
        .clk (clk),
        .arr (arr_if.array)
    );

    dcache_data_ram #(.WAY(1)) data_ram_1 (
        .clk (clk),
        .arr (arr_if.array)
    );

    dcache_tag_ram #(.WAY(0)) tag_ram_0 (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr_if.array)
    );

    dcache_tag_ram #(.WAY(1)) tag_ram_1 (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr_if.array)
    );

    dcache_wb_fsm wb_fsm_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_start      (wb_start),
        .i_line       (wb_line),
        .i_addr       (wb_addr),
        .i_dirty      (wb_dirty),
        .o_finish     (wb_finish),
        .i_clear      (wb_clear),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_bvalid (i_mem_bvalid),
        .o_mem_waddr  (o_mem_waddr),
        .o_mem_wdata  (o_mem_wdata)
    );

endmodule

`default_nettype wire

// ==== hw/dcache_wb_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_wb_fsm (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_start,
    input  dcache_pkg::line_t             i_line,
    input  logic [dcache_pkg::ADDR_W-1:0] i_addr,
    input  logic                          i_dirty,
    output logic                          o_finish,
    input  logic                          i_clear,
    output logic                          o_mem_wvalid,
    input  logic                          i_mem_bvalid,
    output logic [dcache_pkg::ADDR_W-1:0] o_mem_waddr,
    output dcache_pkg::line_t             o_mem_wdata
);

    dcache_pkg::wb_state_e         state_q;
    dcache_pkg::wb_state_e         state_d;
    dcache_pkg::line_t             line_q;
    logic [dcache_pkg::ADDR_W-1:0] addr_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= dcache_pkg::WB_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    // victim copy, the way itself gets overwritten by the refill
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::WB_INIT && i_start) begin
            line_q <= i_line;
            addr_q <= i_addr;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::WB_INIT: begin
                if (i_start) begin
                    // clean victims need no memory write
                    state_d = i_dirty ? dcache_pkg::WB_WRITE : dcache_pkg::WB_FINISH;
                end
            end
            dcache_pkg::WB_WRITE: begin
                if (i_mem_bvalid) begin
                    state_d = dcache_pkg::WB_FINISH;
                end
            end
            dcache_pkg::WB_FINISH: begin
                if (i_clear) begin
                    state_d = dcache_pkg::WB_INIT;
                end
            end
            default: begin
                state_d = dcache_pkg::WB_INIT;
            end
        endcase
    end

    assign o_mem_wvalid = (state_q == dcache_pkg::WB_WRITE);
    assign o_finish     = (state_q == dcache_pkg::WB_FINISH);
    assign o_mem_waddr  = addr_q;
    assign o_mem_wdata  = line_q;

endmodule

`default_nettype wire

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    logic                            clk;
    logic                            rstn;
    logic [dcache_pkg::ADDR_W-1:0]   i_addr;
    logic                            i_rvalid;
    logic                            i_wvalid;
    logic [dcache_pkg::DATA_W-1:0]   i_wdata;
    logic [dcache_pkg::DATA_W/8-1:0] i_wstrb;
    logic                            o_rready;
    logic                            o_wready;
    logic [dcache_pkg::DATA_W-1:0]   o_rdata;
    logic                            o_idle;
    logic                            o_mem_rvalid;
    logic                            i_mem_rready;
    logic [dcache_pkg::ADDR_W-1:0]   o_mem_raddr;
    dcache_pkg::line_t               i_mem_rdata;
    logic                            o_mem_wvalid;
    logic                            i_mem_bvalid;
    logic [dcache_pkg::ADDR_W-1:0]   o_mem_waddr;
    dcache_pkg::line_t               o_mem_wdata;

    // byte-level view of memory as the processor sees it
    logic [7:0]        ref_mem [logic [31:0]];
    logic [31:0]       lcg_state;
    int                refill_count    = 0;
    int                writeback_count = 0;
    logic [31:0]       last_raddr      = '0;
    logic [31:0]       last_waddr      = '0;
    dcache_pkg::line_t last_wdata      = '0;

    dcache_top dcache_top_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_addr       (i_addr),
        .i_rvalid     (i_rvalid),
        .i_wvalid     (i_wvalid),
        .i_wdata      (i_wdata),
        .i_wstrb      (i_wstrb),
        .o_rready     (o_rready),
        .o_wready     (o_wready),
        .o_rdata      (o_rdata),
        .o_idle       (o_idle),
        .o_mem_rvalid (o_mem_rvalid),
        .i_mem_rready (i_mem_rready),
        .o_mem_raddr  (o_mem_raddr),
        .i_mem_rdata  (i_mem_rdata),
        .o_mem_wvalid (o_mem_wvalid),
        .i_mem_bvalid (i_mem_bvalid),
        .o_mem_waddr  (o_mem_waddr),
        .o_mem_wdata  (o_mem_wdata)
    );

    dcache_tb_mem mem_i (
        .clk      (clk),
        .rstn     (rstn),
        .i_rvalid (o_mem_rvalid),
        .o_rready (i_mem_rready),
        .i_raddr  (o_mem_raddr),
        .o_rdata  (i_mem_rdata),
        .i_wvalid (o_mem_wvalid),
        .o_bvalid (i_mem_bvalid),
        .i_waddr  (o_mem_waddr),
        .i_wdata  (o_mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // same fill pattern as the memory model
    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h2545_f491);
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] a);
        logic [31:0] w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        w = pattern_word({a[31:2], 2'b00});
        return w[a[1:0]*8 +: 8];
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:2], 2'b00};
        return {ref_byte(base + 3), ref_byte(base + 2), ref_byte(base + 1), ref_byte(base)};
    endfunction

    function automatic dcache_pkg::line_t line_from_model(input logic [31:0] a);
        dcache_pkg::line_t l;
        for (int b = 0; b < dcache_pkg::LINE_BYTES; b++) begin
            l[b*8 +: 8] = ref_byte({a[31:4], 4'h0} + 32'(b));
        end
        return l;
    endfunction

    task automatic record_store(input logic [31:0] a, input logic [31:0] d,
                                input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[{a[31:2], 2'b00} + 32'(b)] = d[b*8 +: 8];
            end
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (act === exp)
            else abort_run($sformatf("Error: %s expected %0h actual %0h", name, exp, act));
    endtask

    task automatic wait_until_idle(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_idle) begin
            cycles++;
            if (cycles > 40) begin
                abort_run({"timeout waiting for the cache to go idle before ", name});
            end
            @(negedge clk);
        end
    endtask

    // single request returning read data and the cycles to its ready pulse
    task automatic cache_access(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata, input logic [3:0] wstrb,
                                input string name, output logic [31:0] rdata,
                                output int cycles);
        logic done;
        done   = 1'b0;
        cycles = 0;
        rdata  = '0;
        wait_until_idle(name);
        @(posedge clk);
        i_addr   <= addr;
        i_wdata  <= wdata;
        i_wstrb  <= wstrb;
        i_rvalid <= !wr;
        i_wvalid <= wr;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (wr ? o_wready : o_rready) begin
                done  = 1'b1;
                rdata = o_rdata;
            end else if (cycles > 40) begin
                abort_run({"timeout waiting for the ready pulse in ", name});
            end
        end
        @(posedge clk);
        i_rvalid <= 1'b0;
        i_wvalid <= 1'b0;
    endtask

    // memory channel handshakes
    always @(negedge clk) begin
        if (rstn && o_mem_rvalid && i_mem_rready) begin
            refill_count++;
            last_raddr = o_mem_raddr;
            check_equal("refill address alignment", 4'h0, o_mem_raddr[3:0]);
        end
        if (rstn && o_mem_wvalid && i_mem_bvalid) begin
            writeback_count++;
            last_waddr = o_mem_waddr;
            last_wdata = o_mem_wdata;
            check_equal("write-back address alignment", 4'h0, o_mem_waddr[3:0]);
            check_equal("write-back data", line_from_model(o_mem_waddr), o_mem_wdata);
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] wa;
        logic [31:0] data;
        logic [31:0] rd;
        logic [3:0]  strb;
        logic [23:0] t0;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        int          cycles;
        int          refills_before;
        int          wbs_before;
        rstn      = 1'b0;
        i_addr    = '0;
        i_rvalid  = 1'b0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        lcg_state = 32'h68d9_a42f;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_equal("reset outputs", 5'b10000,
                    {o_idle, o_rready, o_wready, o_mem_rvalid, o_mem_wvalid});

        // cold read in set 9
        r    = next_rand();
        addr = {r[31:8], 4'h9, r[3:2], 2'b00};
        refills_before = refill_count;
        cache_access(1'b0, addr, '0, '0, "cold read", rd, cycles);
        check_equal("cold read refill count", refills_before + 1, refill_count);
        check_equal("cold read refill address", {addr[31:4], 4'h0}, last_raddr);
        check_equal("cold read data", expected_word(addr), rd);

        // same line again without memory traffic
        refills_before = refill_count;
        wbs_before     = writeback_count;
        cache_access(1'b0, addr ^ 32'h8, '0, '0, "hit read", rd, cycles);
        check_equal("hit read refill count", refills_before, refill_count);
        check_equal("hit read write-back count", wbs_before, writeback_count);
        check_equal("hit read latency", 2, cycles);
        check_equal("hit read data", expected_word(addr ^ 32'h8), rd);

        // stores to the resident line and to missing lines in sets 4 to 7
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            if (i % 2 == 0) begin
                wa = {addr[31:4], r[3:2], 2'b00};
            end else begin
                wa = {r[31:8], 2'b01, r[5:4], r[3:2], 2'b00};
            end
            data = next_rand();
            strb = r[19:16];
            cache_access(1'b1, wa, data, strb, "store", rd, cycles);
            record_store(wa, data, strb);
            cache_access(1'b0, wa, '0, '0, "load after store", rd, cycles);
            check_equal("load after store", expected_word(wa), rd);
        end

        // dirty line in set 8 evicted by two newer tags
        r  = next_rand();
        t0 = r[31:8];
        a0 = {t0, 4'h8, 4'h4};
        a1 = {t0 + 24'd1, 4'h8, 4'h0};
        a2 = {t0 + 24'd2, 4'h8, 4'h0};
        data = next_rand();
        cache_access(1'b1, a0, data, 4'hf, "eviction store", rd, cycles);
        record_store(a0, data, 4'hf);
        cache_access(1'b0, a1, '0, '0, "second tag read", rd, cycles);
        check_equal("second tag read", expected_word(a1), rd);
        wbs_before = writeback_count;
        cache_access(1'b0, a2, '0, '0, "third tag read", rd, cycles);
        check_equal("third tag read", expected_word(a2), rd);
        check_equal("eviction write-back count", wbs_before + 1, writeback_count);
        check_equal("eviction write-back address", {a0[31:4], 4'h0}, last_waddr);
        check_equal("eviction write-back line", line_from_model(a0), last_wdata);
        refills_before = refill_count;
        cache_access(1'b0, a0, '0, '0, "evicted line read", rd, cycles);
        check_equal("evicted line refill count", refills_before + 1, refill_count);
        check_equal("evicted line read", expected_word(a0), rd);

        // random mix of four tags over sets 0 to 3
        for (int i = 0; i < 200; i++) begin
            r  = next_rand();
            wa = {24'hc0ffe0 + 24'(r[9:8]), 2'b00, r[5:4], r[3:2], 2'b00};
            if (r[12]) begin
                data = next_rand();
                cache_access(1'b1, wa, data, r[19:16], "random store", rd, cycles);
                record_store(wa, data, r[19:16]);
            end else begin
                cache_access(1'b0, wa, '0, '0, "random load", rd, cycles);
                check_equal("random load", expected_word(wa), rd);
            end
        end

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dcache_tb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb_mem (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          i_rvalid,
    output logic                          o_rready,
    input  logic [dcache_pkg::ADDR_W-1:0] i_raddr,
    output dcache_pkg::line_t             o_rdata,
    input  logic                          i_wvalid,
    output logic                          o_bvalid,
    input  logic [dcache_pkg::ADDR_W-1:0] i_waddr,
    input  dcache_pkg::line_t             i_wdata
);

    // written-back lines only, the rest comes from the fill pattern
    dcache_pkg::line_t lines [logic [dcache_pkg::ADDR_W-1:0]];

    logic [31:0]       seed_q    = 32'h68d9_a42f;
    logic              rready_q  = 1'b0;
    logic              rd_busy_q = 1'b0;
    logic [2:0]        rd_cnt_q  = 3'd0;
    dcache_pkg::line_t rdata_q   = '0;
    logic              bvalid_q  = 1'b0;
    logic              wr_busy_q = 1'b0;
    logic [2:0]        wr_cnt_q  = 3'd0;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h2545_f491);
    endfunction

    function automatic dcache_pkg::line_t line_at(input logic [31:0] a);
        dcache_pkg::line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
            l[w*32 +: 32] = fill_word(a + 32'(4 * w));
        end
        return l;
    endfunction

    // refill channel, 1 to 4 cycles of latency
    always @(posedge clk) begin
        if (!rstn) begin
            seed_q    <= 32'h68d9_a42f;
            rready_q  <= 1'b0;
            rd_busy_q <= 1'b0;
            rd_cnt_q  <= 3'd0;
        end else begin
            seed_q <= lcg_step(seed_q);
            if (rready_q) begin
                rready_q  <= 1'b0;
                rd_busy_q <= 1'b0;
            end else if (i_rvalid && !rd_busy_q) begin
                rd_busy_q <= 1'b1;
                rd_cnt_q  <= 3'd1 + 3'(seed_q[17:16]);
            end else if (rd_busy_q) begin
                if (rd_cnt_q == 3'd1) begin
                    rready_q <= 1'b1;
                    rdata_q  <= line_at(i_raddr);
                end else begin
                    rd_cnt_q <= rd_cnt_q - 3'd1;
                end
            end
        end
    end

    // write-back channel, line stored when the response goes out
    always @(posedge clk) begin
        if (!rstn) begin
            bvalid_q  <= 1'b0;
            wr_busy_q <= 1'b0;
            wr_cnt_q  <= 3'd0;
        end else if (bvalid_q) begin
            bvalid_q  <= 1'b0;
            wr_busy_q <= 1'b0;
        end else if (i_wvalid && !wr_busy_q) begin
            wr_busy_q <= 1'b1;
            wr_cnt_q  <= 3'd1 + 3'(seed_q[25:24]);
        end else if (wr_busy_q) begin
            if (wr_cnt_q == 3'd1) begin
                bvalid_q       <= 1'b1;
                lines[i_waddr]  = i_wdata;
            end else begin
                wr_cnt_q <= wr_cnt_q - 3'd1;
            end
        end
    end

    assign o_rready = rready_q;
    assign o_rdata  = rdata_q;
    assign o_bvalid = bvalid_q;

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/dcache_pkg.sv
hw/dcache_array_if.sv
hw/dcache_data_ram.sv
hw/dcache_tag_ram.sv
hw/dcache_wb_fsm.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_tb_mem.sv
verif/dcache_tb.sv
